// ==== line_draw_params.svh ====
`ifndef LINE_DRAW_PARAMS_SVH
`define LINE_DRAW_PARAMS_SVH

// width of one screen coordinate
`define LD_COORD_W 10

// frame buffer select field inside the burst address
`define LD_FB_SEL_W 6

// burst memory address width
`define LD_ADDR_W 31

// entries in each request queue
`define LD_FIFO_DEPTH 4

`endif

// ==== line_draw_pkg.sv ====
`include "line_draw_params.svh"

package line_draw_pkg;

  typedef enum logic [2:0] {
    op_color      = 3'd0,
    op_point0     = 3'd1,
    op_point1     = 3'd2,
    op_frame_base = 3'd3,
    op_draw       = 3'd4
  } line_op_e;

  typedef struct packed {
    logic [`LD_COORD_W-1:0] x;
    logic [`LD_COORD_W-1:0] y;
  } line_point_t;

  // color view of a command word
  typedef struct packed {
    logic [7:0] pad;
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;
  } cmd_color_t;

  // point view of a command word
  typedef struct packed {
    logic [11:0] pad;
    line_point_t pt;
  } cmd_point_t;

  typedef union packed {
    cmd_color_t  color;
    cmd_point_t  point;
    logic [31:0] raw;
  } cmd_word_u;

  typedef struct packed {
    logic [`LD_ADDR_W-1:0] addr;
  } mem_cmd_t;

  // mask bit low means the byte is written
  typedef struct packed {
    logic [127:0] data;
    logic [15:0]  mask;
  } wdf_beat_t;

endpackage

// ==== line_cmd_decoder.sv ====
`timescale 1ns/1ps
`include "line_draw_params.svh"

module line_cmd_decoder
  import line_draw_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    cmd_valid,
  input  line_op_e                cmd_op,
  input  cmd_word_u               cmd_data,
  input  logic                    le_ready,
  output logic                    color_valid,
  output logic                    point0_valid,
  output logic                    point1_valid,
  output logic                    trigger,
  output logic [23:0]             color,
  output line_point_t             point,
  output logic [`LD_FB_SEL_W-1:0] fb_sel
);

  logic        take;
  logic [31:0] frame_base;
  logic [31:0] frame_base_div8;

  // engine busy means the command is dropped
  assign take = cmd_valid && le_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      color_valid  <= 1'b0;
      point0_valid <= 1'b0;
      point1_valid <= 1'b0;
      trigger      <= 1'b0;
      frame_base   <= '0;
    end else begin
      color_valid  <= take && (cmd_op == op_color);
      point0_valid <= take && (cmd_op == op_point0);
      point1_valid <= take && (cmd_op == op_point1);
      trigger      <= take && (cmd_op == op_draw);
      // frame base is taken even while a line is drawn
      if (cmd_valid && (cmd_op == op_frame_base)) begin
        frame_base <= cmd_data.raw;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take && (cmd_op == op_color)) begin
      color <= {cmd_data.color.red, cmd_data.color.green, cmd_data.color.blue};
    end
    // both end points share one payload register
    if (take && ((cmd_op == op_point0) || (cmd_op == op_point1))) begin
      point <= cmd_data.point.pt;
    end
  end

  assign frame_base_div8 = frame_base >> 3;
  assign fb_sel          = frame_base_div8[24:19];

endmodule

// ==== line_engine.sv ====
`timescale 1ns/1ps
`include "line_draw_params.svh"

module line_engine
  import line_draw_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    color_valid,
  input  logic                    point0_valid,
  input  logic                    point1_valid,
  input  logic                    trigger,
  input  logic [23:0]             color,
  input  line_point_t             point,
  input  logic [`LD_FB_SEL_W-1:0] fb_sel,
  input  logic                    af_full,
  input  logic                    wdf_full,
  output logic                    ready,
  output logic                    af_wr,
  output mem_cmd_t                af_cmd,
  output logic                    wdf_wr,
  output wdf_beat_t               wdf_beat
);

  localparam int CW = `LD_COORD_W;

  typedef enum logic [2:0] {
    idle,
    set_up,
    line_setup,
    write_1,
    write_2
  } state_e;

  state_e state, state_next;

  // end points as given by the host
  logic [CW-1:0] x0, y0, x1, y1;
  logic [23:0]   color_q;
  logic [`LD_FB_SEL_W-1:0] fb_sel_q;

  // walk state in major/minor terms
  logic          steep;
  logic [CW-1:0] maj, maj_end, mnr;
  logic          mnr_dec;
  logic [CW-1:0] d_maj, d_mnr;
  logic signed [CW+1:0] err;

  // line setup terms
  logic          steep_c;
  logic [CW-1:0] adx, ady;
  logic [CW-1:0] a0, b0, a1, b1;
  logic [CW-1:0] maj_lo, maj_hi, mnr_lo, mnr_hi;

  // per pixel terms
  logic signed [CW+1:0] err_sub;
  logic [CW-1:0] row, col;
  logic [1:0]    lane;
  logic [15:0]   mask_1, mask_2;
  logic          push_1, push_2, last_px;

  always_comb begin
    adx     = (x1 >= x0) ? x1 - x0 : x0 - x1;
    ady     = (y1 >= y0) ? y1 - y0 : y0 - y1;
    steep_c = ady > adx;
    a0      = steep_c ? y0 : x0;
    b0      = steep_c ? x0 : y0;
    a1      = steep_c ? y1 : x1;
    b1      = steep_c ? x1 : y1;
    // always walk the major axis upwards
    if (a0 > a1) begin
      maj_lo = a1;
      maj_hi = a0;
      mnr_lo = b1;
      mnr_hi = b0;
    end else begin
      maj_lo = a0;
      maj_hi = a1;
      mnr_lo = b0;
      mnr_hi = b1;
    end
  end

  assign err_sub = err - $signed({2'b00, d_mnr});
  assign last_px = (maj == maj_end);

  assign push_1 = (state == write_1) && !af_full && !wdf_full;
  assign push_2 = (state == write_2) && !wdf_full;

  always_comb begin
    state_next = state;
    case (state)
      idle:       if (color_valid) state_next = set_up;
      set_up:     if (trigger) state_next = line_setup;
      line_setup: state_next = write_1;
      write_1:    if (push_1) state_next = write_2;
      write_2: begin
        if (push_2) begin
          state_next = last_px ? idle : write_1;
        end
      end
      default:    state_next = idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= idle;
    end else begin
      state <= state_next;
    end
  end

  always_ff @(posedge clk) begin
    if ((state == idle) || (state == set_up)) begin
      if (color_valid) color_q <= color;
      if (point0_valid) begin
        x0 <= point.x;
        y0 <= point.y;
      end
      if (point1_valid) begin
        x1 <= point.x;
        y1 <= point.y;
      end
    end
    if (state == line_setup) begin
      steep    <= steep_c;
      fb_sel_q <= fb_sel;
      maj      <= maj_lo;
      maj_end  <= maj_hi;
      mnr      <= mnr_lo;
      mnr_dec  <= mnr_lo > mnr_hi;
      d_maj    <= maj_hi - maj_lo;
      d_mnr    <= (mnr_hi >= mnr_lo) ? mnr_hi - mnr_lo : mnr_lo - mnr_hi;
      err      <= $signed({2'b00, (maj_hi - maj_lo) >> 1});
    end
    // step only once beat 2 has left
    if (push_2 && !last_px) begin
      maj <= maj + 1'b1;
      if (err_sub < 0) begin
        mnr <= mnr_dec ? mnr - 1'b1 : mnr + 1'b1;
        err <= err_sub + $signed({2'b00, d_maj});
      end else begin
        err <= err_sub;
      end
    end
  end

  // swap back to screen x and y
  assign row  = steep ? maj : mnr;
  assign col  = steep ? mnr : maj;
  assign lane = ~col[1:0];

  // pixel n of a beat clears nibble 3-n
  always_comb begin
    mask_1 = 16'hffff;
    mask_2 = 16'hffff;
    if (!col[2]) begin
      mask_1[{lane, 2'b00} +: 4] = 4'h0;
    end else begin
      mask_2[{lane, 2'b00} +: 4] = 4'h0;
    end
  end

  assign ready       = (state == idle) || (state == set_up);
  assign af_wr       = push_1;
  assign af_cmd.addr = {6'b0, fb_sel_q, row, col[CW-1:3], 2'b00};
  assign wdf_wr      = push_1 || push_2;
  assign wdf_beat.data = {4{8'h00, color_q}};
  assign wdf_beat.mask = (state == write_2) ? mask_2 : mask_1;

endmodule

// ==== mem_req_fifo.sv ====
`timescale 1ns/1ps
`include "line_draw_params.svh"

module mem_req_fifo #(
  parameter int WIDTH = 31
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             wr,
  input  logic [WIDTH-1:0] din,
  input  logic             rd_en,
  output logic [WIDTH-1:0] dout,
  output logic             valid,
  output logic             full
);

  localparam int DEPTH = `LD_FIFO_DEPTH;
  localparam int AW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  logic [WIDTH-1:0] mem [DEPTH];
  logic [AW-1:0]    wr_ptr, rd_ptr;
  logic [AW:0]      count;
  logic             do_wr, do_rd;

  assign do_wr = wr && !full;
  // a read enable with nothing stored is ignored
  assign do_rd = rd_en && valid;

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // head entry is visible without a read
  assign dout  = mem[rd_ptr];
  assign valid = (count != '0);
  assign full  = (count == (AW + 1)'(DEPTH));

endmodule

// ==== line_draw_top.sv ====
`timescale 1ns/1ps
`include "line_draw_params.svh"

module line_draw_top
  import line_draw_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      cmd_valid,
  input  line_op_e  cmd_op,
  input  cmd_word_u cmd_data,
  input  logic      af_rd_en,
  input  logic      wdf_rd_en,
  output logic      ready,
  output mem_cmd_t  af_dout,
  output logic      af_valid,
  output wdf_beat_t wdf_dout,
  output logic      wdf_valid
);

  logic                    color_valid, point0_valid, point1_valid, trigger;
  logic [23:0]             color;
  line_point_t             point;
  logic [`LD_FB_SEL_W-1:0] fb_sel;
  logic                    af_wr, af_full, wdf_wr, wdf_full;
  mem_cmd_t                af_cmd;
  wdf_beat_t               wdf_beat;

  line_cmd_decoder u_decoder (
    .clk          (clk),
    .rst          (rst),
    .cmd_valid    (cmd_valid),
    .cmd_op       (cmd_op),
    .cmd_data     (cmd_data),
    .le_ready     (ready),
    .color_valid  (color_valid),
    .point0_valid (point0_valid),
    .point1_valid (point1_valid),
    .trigger      (trigger),
    .color        (color),
    .point        (point),
    .fb_sel       (fb_sel)
  );

  line_engine u_engine (
    .clk          (clk),
    .rst          (rst),
    .color_valid  (color_valid),
    .point0_valid (point0_valid),
    .point1_valid (point1_valid),
    .trigger      (trigger),
    .color        (color),
    .point        (point),
    .fb_sel       (fb_sel),
    .af_full      (af_full),
    .wdf_full     (wdf_full),
    .ready        (ready),
    .af_wr        (af_wr),
    .af_cmd       (af_cmd),
    .wdf_wr       (wdf_wr),
    .wdf_beat     (wdf_beat)
  );

  // address queue
  mem_req_fifo #(.WIDTH($bits(mem_cmd_t))) u_af (
    .clk   (clk),
    .rst   (rst),
    .wr    (af_wr),
    .din   (af_cmd),
    .rd_en (af_rd_en),
    .dout  (af_dout),
    .valid (af_valid),
    .full  (af_full)
  );

  // write data queue
  mem_req_fifo #(.WIDTH($bits(wdf_beat_t))) u_wdf (
    .clk   (clk),
    .rst   (rst),
    .wr    (wdf_wr),
    .din   (wdf_beat),
    .rd_en (wdf_rd_en),
    .dout  (wdf_dout),
    .valid (wdf_valid),
    .full  (wdf_full)
  );

endmodule

// ==== tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int HALF_PERIOD_NS = 4
) (
  output logic clk
);

  // 8 ns period
  initial begin
    clk = 1'b0;
  end

  always #(HALF_PERIOD_NS) clk = ~clk;

endmodule

// ==== line_draw_tb.sv ====
`timescale 1ns/1ps

module line_draw_tb
  import line_draw_pkg::*;
;

  localparam int WAIT_LIMIT  = 200;
  localparam int DRAIN_LIMIT = 4000;

  logic      clk;
  logic      rst;
  logic      cmd_valid;
  line_op_e  cmd_op;
  cmd_word_u cmd_data;
  logic      af_rd_en;
  logic      wdf_rd_en;
  logic      ready;
  mem_cmd_t  af_dout;
  logic      af_valid;
  wdf_beat_t wdf_dout;
  logic      wdf_valid;

  integer seed = 32'h862f_8b20;
  int     errors = 0;
  int     timeouts = 0;
  logic [31:0] cur_fb = 32'h0;

  logic [30:0]  exp_addr[$];
  logic [143:0] exp_beat[$];
  logic [30:0]  got_addr[$];
  logic [143:0] got_beat[$];

  tb_clk_gen u_clk_gen (.clk(clk));

  line_draw_top u_line_draw_top (
    .clk       (clk),
    .rst       (rst),
    .cmd_valid (cmd_valid),
    .cmd_op    (cmd_op),
    .cmd_data  (cmd_data),
    .af_rd_en  (af_rd_en),
    .wdf_rd_en (wdf_rd_en),
    .ready     (ready),
    .af_dout   (af_dout),
    .af_valid  (af_valid),
    .wdf_dout  (wdf_dout),
    .wdf_valid (wdf_valid)
  );

  task automatic check_val(input string name, input logic [143:0] got,
                           input logic [143:0] exp);
    if (got !== exp) begin
      $display("FAIL %s: got %0h, expected %0h", name, got, exp);
      errors++;
    end
  endtask

  // one cycle strobe, no look at ready
  task automatic drive_cmd(input line_op_e op, input logic [31:0] word);
    cmd_valid    = 1'b1;
    cmd_op       = op;
    cmd_data.raw = word;
    @(posedge clk);
    #1;
    cmd_valid = 1'b0;
  endtask

  task automatic send_cmd(input line_op_e op, input logic [31:0] word);
    int cycles;
    cycles = 0;
    while (!ready && (cycles < WAIT_LIMIT)) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (!ready) begin
      $display("timeout: ready stayed low before a host command");
      timeouts++;
    end else begin
      drive_cmd(op, word);
    end
  endtask

  // wait until the engine has left its command states
  task automatic wait_busy();
    int cycles;
    cycles = 0;
    while (ready && (cycles < WAIT_LIMIT)) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (ready) begin
      $display("timeout: ready never dropped after the draw command");
      timeouts++;
    end
  endtask

  task automatic start_line(input int x0, input int y0, input int x1, input int y1,
                            input logic [23:0] color);
    send_cmd(op_color, {8'h00, color});
    send_cmd(op_point0, {12'h000, 10'(x0), 10'(y0)});
    send_cmd(op_point1, {12'h000, 10'(x1), 10'(y1)});
    send_cmd(op_draw, 32'h0);
  endtask

  // reference Bresenham walk with an integer error term
  task automatic build_expected(input int x0, input int y0, input int x1, input int y1,
                                input logic [23:0] color, input logic [31:0] fb_base);
    int adx, ady, a0, b0, a1, b1, t;
    int maj, mnr, step, d_maj, d_mnr, err, row, col, nib;
    logic         steep;
    logic [31:0]  fb_div8;
    logic [5:0]   sel;
    logic [15:0]  m1, m2;
    logic [127:0] data;
    exp_addr.delete();
    exp_beat.delete();
    adx   = (x1 >= x0) ? x1 - x0 : x0 - x1;
    ady   = (y1 >= y0) ? y1 - y0 : y0 - y1;
    steep = ady > adx;
    a0 = steep ? y0 : x0;
    b0 = steep ? x0 : y0;
    a1 = steep ? y1 : x1;
    b1 = steep ? x1 : y1;
    if (a0 > a1) begin
      t = a0;
      a0 = a1;
      a1 = t;
      t = b0;
      b0 = b1;
      b1 = t;
    end
    d_maj   = a1 - a0;
    d_mnr   = (b1 >= b0) ? b1 - b0 : b0 - b1;
    step    = (b1 >= b0) ? 1 : -1;
    err     = d_maj / 2;
    mnr     = b0;
    fb_div8 = fb_base >> 3;
    sel     = fb_div8[24:19];
    data    = {4{8'h00, color}};
    for (maj = a0; maj <= a1; maj++) begin
      row = steep ? maj : mnr;
      col = steep ? mnr : maj;
      exp_addr.push_back({6'b0, sel, 10'(row), 7'(col >> 3), 2'b00});
      // pixels 0..3 of a burst in beat 1, 4..7 in beat 2
      nib = 3 - (col % 4);
      m1  = 16'hffff;
      m2  = 16'hffff;
      if ((col % 8) < 4) begin
        m1[nib*4 +: 4] = 4'h0;
      end else begin
        m2[nib*4 +: 4] = 4'h0;
      end
      exp_beat.push_back({data, m1});
      exp_beat.push_back({data, m2});
      err = err - d_mnr;
      if (err < 0) begin
        mnr = mnr + step;
        err = err + d_maj;
      end
    end
  endtask

  // mode 0 reads every cycle, mode 1 pauses the read enables at random
  task automatic collect_line(input int mode);
    int   cycles;
    logic a_rd, w_rd;
    got_addr.delete();
    got_beat.delete();
    cycles = 0;
    while (!((got_addr.size() >= exp_addr.size()) && (got_beat.size() >= exp_beat.size())
             && ready) && (cycles < DRAIN_LIMIT)) begin
      a_rd = 1'b1;
      w_rd = 1'b1;
      if (mode == 1) begin
        a_rd = ($random(seed) & 3) != 0;
        w_rd = ($random(seed) & 3) != 0;
      end
      // head entry is what pops at the coming edge
      if (a_rd && af_valid) got_addr.push_back(af_dout.addr);
      if (w_rd && wdf_valid) got_beat.push_back(wdf_dout);
      af_rd_en  = a_rd;
      wdf_rd_en = w_rd;
      @(posedge clk);
      #1;
      cycles++;
    end
    if (cycles >= DRAIN_LIMIT) begin
      $display("timeout: line did not finish while draining the FIFOs");
      timeouts++;
    end
    check_val("af_valid after line", 144'(af_valid), 144'(1'b0));
    check_val("wdf_valid after line", 144'(wdf_valid), 144'(1'b0));
    af_rd_en  = 1'b0;
    wdf_rd_en = 1'b0;
  endtask

  task automatic compare_line();
    check_val("af entry count", 144'(got_addr.size()), 144'(exp_addr.size()));
    check_val("wdf entry count", 144'(got_beat.size()), 144'(exp_beat.size()));
    for (int i = 0; (i < got_addr.size()) && (i < exp_addr.size()); i++) begin
      check_val($sformatf("af_dout[%0d]", i), 144'(got_addr[i]), 144'(exp_addr[i]));
    end
    for (int i = 0; (i < got_beat.size()) && (i < exp_beat.size()); i++) begin
      check_val($sformatf("wdf_dout pixel %0d beat %0d", i / 2, (i % 2) + 1),
                got_beat[i], exp_beat[i]);
    end
    check_val("ready after line", 144'(ready), 144'(1'b1));
  endtask

  task automatic check_reset_state();
    check_val("ready", 144'(ready), 144'(1'b1));
    check_val("af_valid", 144'(af_valid), 144'(1'b0));
    check_val("wdf_valid", 144'(wdf_valid), 144'(1'b0));
  endtask

  task automatic draw_shallow_line();
    build_expected(3, 5, 20, 11, 24'h123456, cur_fb);
    start_line(3, 5, 20, 11, 24'h123456);
    collect_line(0);
    compare_line();
  endtask

  // end points reversed, walk still goes up in y
  task automatic draw_steep_reversed();
    build_expected(30, 40, 25, 10, 24'hab01cd, cur_fb);
    start_line(30, 40, 25, 10, 24'hab01cd);
    collect_line(0);
    compare_line();
  endtask

  task automatic switch_frame_base();
    send_cmd(op_frame_base, 32'h0a00_0000);
    cur_fb = 32'h0a00_0000;
    build_expected(0, 0, 9, 3, 24'h00ff00, cur_fb);
    start_line(0, 0, 9, 3, 24'h00ff00);
    wait_busy();
    // new base arrives mid-line, only the next line sees it
    drive_cmd(op_frame_base, 32'h0340_0000);
    collect_line(0);
    compare_line();
    cur_fb = 32'h0340_0000;
    build_expected(7, 2, 15, 6, 24'hff0000, cur_fb);
    start_line(7, 2, 15, 6, 24'hff0000);
    collect_line(0);
    compare_line();
  endtask

  task automatic drain_with_stalls();
    build_expected(10, 60, 50, 45, 24'h5a5a5a, cur_fb);
    start_line(10, 60, 50, 45, 24'h5a5a5a);
    collect_line(1);
    compare_line();
  endtask

  task automatic ignore_busy_color();
    build_expected(5, 5, 17, 9, 24'h0f0f0f, cur_fb);
    start_line(5, 5, 17, 9, 24'h0f0f0f);
    wait_busy();
    drive_cmd(op_color, 32'h00e0e0e0);
    collect_line(0);
    compare_line();
  endtask

  initial begin
    rst       = 1'b1;
    cmd_valid = 1'b0;
    cmd_op    = op_color;
    cmd_data  = '0;
    af_rd_en  = 1'b0;
    wdf_rd_en = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    check_reset_state();
    draw_shallow_line();
    draw_steep_reversed();
    switch_frame_base();
    drain_with_stalls();
    ignore_busy_color();
    $display("errors: %0d mismatches, %0d timeouts", errors, timeouts);
    if ((errors == 0) && (timeouts == 0)) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== line_draw.f ====
+incdir+.
line_draw_pkg.sv
line_cmd_decoder.sv
line_engine.sv
mem_req_fifo.sv
line_draw_top.sv
tb_clk_gen.sv
line_draw_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the line draw testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f line_draw.f \
  --top-module line_draw_tb -o line_draw_sim > build.log 2>&1 \
  || { echo "build failed, see build.log"; exit 1; }

./obj_dir/line_draw_sim > sim.log 2>&1
grep -q "^TB PASSED$" sim.log && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }
